/* rtl/mania_pkg.sv */
// table geometry, tick periods, sequencer and scanner state enums
`default_nettype none

package mania_pkg;

	// four sections per table
	localparam int NUM_SECTIONS = 4;
	localparam int SEC_W        = 2;

	// beatmap table, one word per header
	localparam int DB_ADDR_W = 13;
	localparam int DB_DATA_W = 24; // size sits in the low DB_ADDR_W bits

	// object table, four nibbles per header, lsn first
	localparam int DO_ADDR_W      = 12;
	localparam int DO_DATA_W      = 4;
	localparam int DO_HDR_NIBBLES = 4;

	// addr/en in phase 0, data captured in phase 3
	localparam int READ_PHASES = 4;

	// tick periods in clock cycles, scaled down for simulation
	localparam int UPDATE_PERIOD = 50;
	localparam int AUDIO_PERIOD  = 7;
	localparam int TICK_CNT_W    = 8;

	typedef enum logic [2:0] {
		S_START,   // raise both requests
		S_SCAN,    // wait for both acks
		S_RELEASE, // drop requests, wait for acks to fall
		S_RUN,
		S_PAUSE
	} seq_state_e;

	typedef enum logic [1:0] {
		SC_IDLE,
		SC_READ,
		SC_ACK
	} scan_state_e;

endpackage

`default_nettype wire

/* rtl/chain_header_scanner.sv */
// chain_header_scanner: walks the beatmap table of one-word section headers
`timescale 1ns/10ps
`default_nettype none

module chain_header_scanner (
	input  wire                             CLK,
	input  wire                             RESET_L,
	input  wire                             scan_req,
	output logic                            scan_ack,
	output logic [mania_pkg::DB_ADDR_W-1:0] rd_addr,
	output logic                            rd_en,
	input  wire  [mania_pkg::DB_DATA_W-1:0] rd_data,
	input  wire  [mania_pkg::SEC_W-1:0]     sec_sel,
	output logic [mania_pkg::DB_ADDR_W-1:0] sec_base,
	output logic [mania_pkg::DB_ADDR_W-1:0] sec_size
);

	mania_pkg::scan_state_e state;
	logic [mania_pkg::SEC_W-1:0] sec; // section being read
	logic [$clog2(mania_pkg::READ_PHASES)-1:0] phase;
	logic [mania_pkg::DB_ADDR_W-1:0] hdr; // current header address
	logic [mania_pkg::DB_ADDR_W-1:0] hdr_size;
	logic [mania_pkg::DB_ADDR_W-1:0] base_q [mania_pkg::NUM_SECTIONS];
	logic [mania_pkg::DB_ADDR_W-1:0] size_q [mania_pkg::NUM_SECTIONS];

	assign hdr_size = rd_data[mania_pkg::DB_ADDR_W-1:0]; // upper bits unused

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state    <= mania_pkg::SC_IDLE;
			sec      <= '0;
			phase    <= '0;
			hdr      <= '0;
			rd_addr  <= '0;
			rd_en    <= 1'b0;
			scan_ack <= 1'b0;
			for (int i = 0; i < mania_pkg::NUM_SECTIONS; i++) begin
				base_q[i] <= '0;
				size_q[i] <= '0;
			end
		end else begin
			case (state)
				mania_pkg::SC_IDLE: begin
					if (scan_req) begin // first header always at 0
						state <= mania_pkg::SC_READ;
						sec   <= '0;
						phase <= '0;
						hdr   <= '0;
					end
				end
				mania_pkg::SC_READ: begin
					phase <= phase + 1'b1;
					if (phase == 0) begin
						rd_addr <= hdr;
						rd_en   <= 1'b1;
					end else if (phase == mania_pkg::READ_PHASES - 1) begin
						rd_en       <= 1'b0;
						size_q[sec] <= hdr_size;
						base_q[sec] <= hdr + 1'b1;
						hdr         <= hdr + 1'b1 + hdr_size; // next header follows the data
						if (sec == mania_pkg::NUM_SECTIONS - 1) begin
							state    <= mania_pkg::SC_ACK;
							scan_ack <= 1'b1;
						end else begin
							sec <= sec + 1'b1;
						end
					end
				end
				mania_pkg::SC_ACK: begin
					if (!scan_req) begin // four-phase, drop ack after req
						scan_ack <= 1'b0;
						state    <= mania_pkg::SC_IDLE;
					end
				end
				default: state <= mania_pkg::SC_IDLE;
			endcase
		end
	end

	assign sec_base = base_q[sec_sel];
	assign sec_size = size_q[sec_sel];

endmodule

`default_nettype wire

/* rtl/nibble_header_scanner.sv */
// object table scanner for four-nibble section headers
`timescale 1ns/10ps
`default_nettype none

module nibble_header_scanner (
	input  wire                             CLK,
	input  wire                             RESET_L,
	input  wire                             scan_req,
	output logic                            scan_ack,
	output logic [mania_pkg::DO_ADDR_W-1:0] rd_addr,
	output logic                            rd_en,
	input  wire  [mania_pkg::DO_DATA_W-1:0] rd_data,
	input  wire  [mania_pkg::SEC_W-1:0]     sec_sel,
	output logic [mania_pkg::DO_ADDR_W-1:0] sec_base,
	output logic [mania_pkg::DO_ADDR_W-1:0] sec_size
);

	mania_pkg::scan_state_e state;
	logic [mania_pkg::SEC_W-1:0] sec;
	logic [$clog2(mania_pkg::READ_PHASES)-1:0] phase;
	logic [$clog2(mania_pkg::DO_HDR_NIBBLES)-1:0] nib; // nibble index within header
	logic [mania_pkg::DO_ADDR_W-1:0] hdr;
	logic [mania_pkg::DO_ADDR_W-1:0] hdr_base; // first data word after the header
	logic [mania_pkg::DO_ADDR_W-1:0] hdr_size;
	logic [mania_pkg::DO_HDR_NIBBLES*mania_pkg::DO_DATA_W-1:0] hdr_acc; // nibbles so far
	logic [mania_pkg::DO_HDR_NIBBLES*mania_pkg::DO_DATA_W-1:0] hdr_word;
	logic [mania_pkg::DO_ADDR_W-1:0] base_q [mania_pkg::NUM_SECTIONS];
	logic [mania_pkg::DO_ADDR_W-1:0] size_q [mania_pkg::NUM_SECTIONS];

	assign hdr_base = hdr + mania_pkg::DO_ADDR_W'(mania_pkg::DO_HDR_NIBBLES);

	// drop the incoming nibble into its slot
	always_comb begin
		hdr_word = hdr_acc;
		hdr_word[nib*mania_pkg::DO_DATA_W +: mania_pkg::DO_DATA_W] = rd_data;
	end

	assign hdr_size = hdr_word[mania_pkg::DO_ADDR_W-1:0]; // top nibble truncated

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state    <= mania_pkg::SC_IDLE;
			sec      <= '0;
			phase    <= '0;
			nib      <= '0;
			hdr      <= '0;
			rd_addr  <= '0;
			rd_en    <= 1'b0;
			scan_ack <= 1'b0;
			for (int i = 0; i < mania_pkg::NUM_SECTIONS; i++) begin
				base_q[i] <= '0;
				size_q[i] <= '0;
			end
		end else begin
			case (state)
				mania_pkg::SC_IDLE: begin
					if (scan_req) begin
						state <= mania_pkg::SC_READ;
						sec   <= '0;
						phase <= '0;
						nib   <= '0;
						hdr   <= '0;
					end
				end
				mania_pkg::SC_READ: begin
					phase <= phase + 1'b1;
					if (phase == 0) begin
						rd_addr <= hdr + nib;
						rd_en   <= 1'b1;
					end else if (phase == mania_pkg::READ_PHASES - 1) begin
						rd_en   <= 1'b0;
						hdr_acc <= hdr_word;
						nib     <= nib + 1'b1;
						// section complete only after the last nibble
						if (nib == mania_pkg::DO_HDR_NIBBLES - 1) begin
							size_q[sec] <= hdr_size;
							base_q[sec] <= hdr_base;
							hdr         <= hdr_base + hdr_size;
							if (sec == mania_pkg::NUM_SECTIONS - 1) begin
								state    <= mania_pkg::SC_ACK;
								scan_ack <= 1'b1;
							end else begin
								sec <= sec + 1'b1;
							end
						end
					end
				end
				mania_pkg::SC_ACK: begin
					if (!scan_req) begin
						scan_ack <= 1'b0;
						state    <= mania_pkg::SC_IDLE;
					end
				end
				default: state <= mania_pkg::SC_IDLE;
			endcase
		end
	end

	assign sec_base = base_q[sec_sel];
	assign sec_size = size_q[sec_sel];

endmodule

`default_nettype wire

/* rtl/boot_sequencer.sv */
// boot_sequencer: FSM that runs both header scans, then holds run or pause
`timescale 1ns/10ps
`default_nettype none

module boot_sequencer (
	input  wire  CLK,
	input  wire  RESET_L,
	input  wire  pause,
	input  wire  db_scan_ack,
	input  wire  do_scan_ack,
	output logic db_scan_req,
	output logic do_scan_req,
	output logic run,
	output logic ready
);

	mania_pkg::seq_state_e state;
	logic both_ack;  // both scans finished
	logic none_ack;  // both acks released

	assign both_ack = db_scan_ack && do_scan_ack;
	assign none_ack = !db_scan_ack && !do_scan_ack;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state       <= mania_pkg::S_START;
			db_scan_req <= 1'b0;
			do_scan_req <= 1'b0;
		end else begin
			case (state)
				mania_pkg::S_START: begin
					// kick both scanners together
					db_scan_req <= 1'b1;
					do_scan_req <= 1'b1;
					state       <= mania_pkg::S_SCAN;
				end
				mania_pkg::S_SCAN: begin
					if (both_ack) begin
						db_scan_req <= 1'b0;
						do_scan_req <= 1'b0;
						state       <= mania_pkg::S_RELEASE;
					end
				end
				mania_pkg::S_RELEASE: begin
					if (none_ack)
						state <= mania_pkg::S_RUN;
				end
				mania_pkg::S_RUN: begin
					if (pause)
						state <= mania_pkg::S_PAUSE;
				end
				mania_pkg::S_PAUSE: begin
					if (!pause)
						state <= mania_pkg::S_RUN;
				end
				default: begin
					db_scan_req <= 1'b0;
					do_scan_req <= 1'b0;
					state       <= mania_pkg::S_START;
				end
			endcase
		end
	end

	// boot done once we reach run or pause, never leaves until reset
	assign ready = (state == mania_pkg::S_RUN) || (state == mania_pkg::S_PAUSE);
	assign run   = (state == mania_pkg::S_RUN);

endmodule

`default_nettype wire

/* rtl/beat_tick_gen.sv */
// beat_tick_gen: update and audio tick counters, counting only while running
`timescale 1ns/10ps
`default_nettype none

module beat_tick_gen (
	input  wire  CLK,
	input  wire  RESET_L,
	input  wire  run,
	output logic update_tick,
	output logic audio_tick
);

	logic [mania_pkg::TICK_CNT_W-1:0] update_cnt;
	logic [mania_pkg::TICK_CNT_W-1:0] audio_cnt;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			update_cnt  <= '0;
			audio_cnt   <= '0;
			update_tick <= 1'b0;
			audio_tick  <= 1'b0;
		end else if (run) begin
			if (update_cnt == mania_pkg::UPDATE_PERIOD - 1) begin
				update_cnt  <= '0;
				update_tick <= 1'b1; // pulse on wrap
			end else begin
				update_cnt  <= update_cnt + 1'b1;
				update_tick <= 1'b0;
			end
			if (audio_cnt == mania_pkg::AUDIO_PERIOD - 1) begin
				audio_cnt  <= '0;
				audio_tick <= 1'b1;
			end else begin
				audio_cnt  <= audio_cnt + 1'b1;
				audio_tick <= 1'b0;
			end
		end else begin
			// paused, counters keep their place
			update_tick <= 1'b0;
			audio_tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/mania_core.sv */
// mania_core: top level with boot sequencer, two header scanners and tick generator
`timescale 1ns/10ps
`default_nettype none

module mania_core (
	input  wire                             CLK,
	input  wire                             RESET_L,
	input  wire                             pause,
	input  wire  [mania_pkg::SEC_W-1:0]     sec_sel,
	output logic [mania_pkg::DB_ADDR_W-1:0] db_addr,
	output logic                            db_en,
	input  wire  [mania_pkg::DB_DATA_W-1:0] db_data,
	output logic [mania_pkg::DO_ADDR_W-1:0] do_addr,
	output logic                            do_en,
	input  wire  [mania_pkg::DO_DATA_W-1:0] do_data,
	output logic                            ready,
	output logic                            update_tick,
	output logic                            audio_tick,
	output logic [mania_pkg::DB_ADDR_W-1:0] db_base,
	output logic [mania_pkg::DB_ADDR_W-1:0] db_size,
	output logic [mania_pkg::DO_ADDR_W-1:0] do_base,
	output logic [mania_pkg::DO_ADDR_W-1:0] do_size
);

	logic db_scan_req;
	logic db_scan_ack;
	logic do_scan_req;
	logic do_scan_ack;
	logic run;

	boot_sequencer u_seq (
		.CLK         (CLK),
		.RESET_L     (RESET_L),
		.pause       (pause),
		.db_scan_ack (db_scan_ack),
		.do_scan_ack (do_scan_ack),
		.db_scan_req (db_scan_req),
		.do_scan_req (do_scan_req),
		.run         (run),
		.ready       (ready)
	);

	// beatmap and object scans run side by side
	chain_header_scanner u_db_scan (
		.CLK      (CLK),
		.RESET_L  (RESET_L),
		.scan_req (db_scan_req),
		.scan_ack (db_scan_ack),
		.rd_addr  (db_addr),
		.rd_en    (db_en),
		.rd_data  (db_data),
		.sec_sel  (sec_sel),
		.sec_base (db_base),
		.sec_size (db_size)
	);

	nibble_header_scanner u_do_scan (
		.CLK      (CLK),
		.RESET_L  (RESET_L),
		.scan_req (do_scan_req),
		.scan_ack (do_scan_ack),
		.rd_addr  (do_addr),
		.rd_en    (do_en),
		.rd_data  (do_data),
		.sec_sel  (sec_sel),
		.sec_base (do_base),
		.sec_size (do_size)
	);

	beat_tick_gen u_ticks (
		.CLK         (CLK),
		.RESET_L     (RESET_L),
		.run         (run),
		.update_tick (update_tick),
		.audio_tick  (audio_tick)
	);

endmodule

`default_nettype wire

/* verification/mania_core_tb.sv */
// mania_core_tb: clock, reset, table memory models, stimulus and assertion checks
`timescale 1ns/10ps
`default_nettype none

module mania_core_tb;

	localparam int NS = mania_pkg::NUM_SECTIONS;

	logic CLK = 1'b0;
	logic RESET_L = 1'b0;
	logic pause = 1'b0;
	logic [mania_pkg::SEC_W-1:0] sec_sel = '0;
	logic [mania_pkg::DB_DATA_W-1:0] db_data = '0;
	logic [mania_pkg::DO_DATA_W-1:0] do_data = '0;
	logic [mania_pkg::DB_ADDR_W-1:0] db_addr;
	logic [mania_pkg::DB_ADDR_W-1:0] db_base;
	logic [mania_pkg::DB_ADDR_W-1:0] db_size;
	logic [mania_pkg::DO_ADDR_W-1:0] do_addr;
	logic [mania_pkg::DO_ADDR_W-1:0] do_base;
	logic [mania_pkg::DO_ADDR_W-1:0] do_size;
	logic db_en;
	logic do_en;
	logic ready;
	logic update_tick;
	logic audio_tick;

	logic [mania_pkg::DB_DATA_W-1:0] db_mem [2**mania_pkg::DB_ADDR_W];
	logic [mania_pkg::DO_DATA_W-1:0] do_mem [2**mania_pkg::DO_ADDR_W];
	int db_hdr [NS];      // expected header addresses
	int db_size_exp [NS];
	int do_hdr [NS];
	int do_size_exp [NS];
	integer seed = 32'h99bb_7ef9;
	int errors = 0;
	int db_reads = 0;
	int do_reads = 0;
	int upd_ticks = 0;
	int aud_ticks = 0;
	int upd_gap;          // running cycles since last tick
	int aud_gap;
	logic db_en_d;
	logic do_en_d;
	logic pause_d;
	logic run_m;          // expected run level seen by the tick counters
	logic run_prev;

	mania_core uut (
		.CLK(CLK), .RESET_L(RESET_L), .pause(pause), .sec_sel(sec_sel),
		.db_addr(db_addr), .db_en(db_en), .db_data(db_data),
		.do_addr(do_addr), .do_en(do_en), .do_data(do_data),
		.ready(ready), .update_tick(update_tick), .audio_tick(audio_tick),
		.db_base(db_base), .db_size(db_size), .do_base(do_base), .do_size(do_size)
	);

	always #50 CLK = ~CLK;

	// both tables answer one cycle after the read
	always @(posedge CLK) begin
		if (db_en)
			db_data <= db_mem[db_addr];
		if (do_en)
			do_data <= do_mem[do_addr];
	end

	task automatic build_tables();
		int hb;
		int ho;
		int sz;
		logic [15:0] hdr_word;
		hb = 0;
		ho = 0;
		for (int a = 0; a < 2**mania_pkg::DB_ADDR_W; a++)
			db_mem[a] = {a[10:0], a[12:0]} ^ 24'h5a_c3a5;
		for (int a = 0; a < 2**mania_pkg::DO_ADDR_W; a++)
			do_mem[a] = a[3:0] ^ a[7:4] ^ a[11:8];
		for (int k = 0; k < NS; k++) begin
			sz = ($unsigned($random(seed)) % 60) + 1;
			db_hdr[k] = hb;
			db_size_exp[k] = sz;
			db_mem[hb] = {11'($unsigned($random(seed))), 13'(sz)}; // junk above the size
			hb = hb + 1 + sz;
			sz = ($unsigned($random(seed)) % 60) + 1;
			hdr_word = {4'(k + 9), 12'(sz)}; // top nibble gets truncated away
			do_hdr[k] = ho;
			do_size_exp[k] = hdr_word[mania_pkg::DO_ADDR_W-1:0];
			for (int n = 0; n < mania_pkg::DO_HDR_NIBBLES; n++)
				do_mem[ho + n] = hdr_word[4*n +: 4];
			ho = ho + mania_pkg::DO_HDR_NIBBLES + do_size_exp[k];
		end
	endtask

	function automatic logic is_db_hdr(input logic [mania_pkg::DB_ADDR_W-1:0] a);
		for (int k = 0; k < NS; k++)
			if (a == db_hdr[k])
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic is_do_hdr(input logic [mania_pkg::DO_ADDR_W-1:0] a);
		for (int k = 0; k < NS; k++)
			for (int n = 0; n < mania_pkg::DO_HDR_NIBBLES; n++)
				if (a == do_hdr[k] + n)
					return 1'b1;
		return 1'b0;
	endfunction

	assert property (@(posedge CLK) !RESET_L |=>
		!ready && !update_tick && !audio_tick && !db_en && !do_en)
	else begin
		errors++;
		$display("CHECK FAILED reset: ready=%h update_tick=%h audio_tick=%h db_en=%h do_en=%h",
			$sampled(ready), $sampled(update_tick), $sampled(audio_tick),
			$sampled(db_en), $sampled(do_en));
	end

	assert property (@(posedge CLK) disable iff (!RESET_L) $rose(db_en) |-> is_db_hdr(db_addr))
	else begin
		errors++;
		$display("CHECK FAILED db_addr: %h is not a header address", $sampled(db_addr));
	end

	assert property (@(posedge CLK) disable iff (!RESET_L) $rose(do_en) |-> is_do_hdr(do_addr))
	else begin
		errors++;
		$display("CHECK FAILED do_addr: %h is not a header nibble address", $sampled(do_addr));
	end

	assert property (@(posedge CLK) disable iff (!RESET_L) ready |=> ready)
	else begin
		errors++;
		$display("ready dropped before reset");
	end

	// read counts and tick spacing in running cycles
	always @(posedge CLK) begin
		if (!RESET_L) begin
			pause_d  = 1'b0;
			run_prev = 1'b0;
			db_en_d  = 1'b0;
			do_en_d  = 1'b0;
			upd_gap  = 0;
			aud_gap  = 0;
		end else begin
			run_m = ready && !pause_d; // pause is registered once inside
			if (db_en && !db_en_d)
				db_reads <= db_reads + 1;
			if (do_en && !do_en_d)
				do_reads <= do_reads + 1;
			if (update_tick) begin
				assert (run_prev)
				else begin
					errors++;
					$display("update_tick came while the core was paused");
				end
				assert (upd_gap == mania_pkg::UPDATE_PERIOD)
				else begin
					errors++;
					$display("CHECK FAILED update_tick spacing: got %h, expected %h",
						upd_gap, mania_pkg::UPDATE_PERIOD);
				end
				upd_gap = 0;
				upd_ticks <= upd_ticks + 1;
			end
			if (audio_tick) begin
				assert (run_prev)
				else begin
					errors++;
					$display("audio_tick came while the core was paused");
				end
				assert (aud_gap == mania_pkg::AUDIO_PERIOD)
				else begin
					errors++;
					$display("CHECK FAILED audio_tick spacing: got %h, expected %h",
						aud_gap, mania_pkg::AUDIO_PERIOD);
				end
				aud_gap = 0;
				aud_ticks <= aud_ticks + 1;
			end
			if (run_m) begin
				upd_gap++;
				aud_gap++;
			end
			run_prev = run_m;
			pause_d  = pause;
			db_en_d  = db_en;
			do_en_d  = do_en;
		end
	end

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
		else begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_sections();
		for (int s = 0; s < NS; s++) begin
			@(posedge CLK);
			sec_sel <= mania_pkg::SEC_W'(s);
			@(negedge CLK);
			check_hex($sformatf("db_base[%0d]", s), db_base, db_hdr[s] + 1);
			check_hex($sformatf("db_size[%0d]", s), db_size, db_size_exp[s]);
			check_hex($sformatf("do_base[%0d]", s), do_base,
				do_hdr[s] + mania_pkg::DO_HDR_NIBBLES);
			check_hex($sformatf("do_size[%0d]", s), do_size, do_size_exp[s]);
		end
	endtask

	task automatic wait_ready(output logic ok);
		int i;
		i = 0;
		while (!ready && i < 2000) begin
			@(posedge CLK);
			i++;
		end
		ok = ready;
		if (!ok) begin
			errors++;
			$display("Timed out waiting for ready after reset");
		end
	endtask

	task automatic wait_ticks(input int target, output logic ok);
		int i;
		i = 0;
		while (upd_ticks < target && i < 1000) begin
			@(posedge CLK);
			i++;
		end
		ok = (upd_ticks >= target);
		if (!ok) begin
			errors++;
			$display("Timed out waiting for update ticks");
		end
	endtask

	initial begin
		logic ok;
		build_tables();
		repeat (10) @(posedge CLK);
		RESET_L <= 1'b1;
		wait_ready(ok);
		if (ok) begin
			check_hex("db read count", db_reads, NS);
			check_hex("do read count", do_reads, NS * mania_pkg::DO_HDR_NIBBLES);
			check_sections();
			wait_ticks(2, ok);
		end
		if (ok) begin
			repeat (17) @(posedge CLK); // land mid-period
			pause <= 1'b1;
			repeat (40) @(posedge CLK);
			pause <= 1'b0;
			wait_ticks(upd_ticks + 3, ok);
		end
		$display("errors: %0d, update ticks: %0d, audio ticks: %0d",
			errors, upd_ticks, aud_ticks);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mania_core.f */
rtl/mania_pkg.sv
rtl/chain_header_scanner.sv
rtl/nibble_header_scanner.sv
rtl/boot_sequencer.sv
rtl/beat_tick_gen.sv
rtl/mania_core.sv
verification/mania_core_tb.sv
